/* flist.f */
design/rv_pkg.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/branch_unit.sv
design/rv_exec.sv
sim/rv_exec_props.sv
sim/rv_exec_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f flist.f \
		--top-module rv_exec_tb -Mdir obj_dir
	./obj_dir/Vrv_exec_tb | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/rv_exec_tb.sv */
// testbench for rv_exec; runs a directed instruction table, then random register ops checked by a model
`timescale 1ns/1ns
`default_nettype none

module rv_exec_tb;
    import rv_pkg::*;

    localparam int reset_cycles = 10;
    localparam int rand_count   = 40;
    // two register loads of two instructions each, then two dependent ops
    localparam int rand_len     = 6;

    typedef struct packed {
        logic [31:0] ins;
        logic [31:0] data;
        logic [31:0] npc;
        logic        valid;
        logic        taken;
        logic        ill;
    } entry_t;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       wb_pc;
    logic                  branch_taken;
    logic                  illegal;

    entry_t      table_q[$];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    int          errors;
    int          checked;
    int          cycles;
    int          cycle_limit;

    // instruction accepted on the last edge, still waiting for its check
    logic        pend;
    logic [31:0] p_ins;
    logic [31:0] p_data;
    logic [31:0] p_npc;
    logic [31:0] p_pc;
    logic        p_valid;
    logic        p_taken;
    logic        p_ill;

    rv_exec dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .wb_pc        (wb_pc),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // instruction formats of the base isa
    function automatic logic [31:0] imm_format(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] reg_format(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] upper_format(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] branch_format(input logic [12:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] jump_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // register-register kinds: add sub sll slt sltu xor srl sra or and mul
    function automatic logic [31:0] rr_instr(input int kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'h00;
        case (kind)
            1:       begin f7 = 7'h20; f3 = 3'd0; end
            2:       f3 = 3'd1;
            3:       f3 = 3'd2;
            4:       f3 = 3'd3;
            5:       f3 = 3'd4;
            6:       f3 = 3'd5;
            7:       begin f7 = 7'h20; f3 = 3'd5; end
            8:       f3 = 3'd6;
            9:       f3 = 3'd7;
            10:      begin f7 = 7'h01; f3 = 3'd0; end
            default: f3 = 3'd0;
        endcase
        return reg_format(f7, rs2, rs1, f3, rd, op_alu);
    endfunction

    function automatic logic [31:0] rr_expect(input int kind, input logic [31:0] a,
                                              input logic [31:0] b);
        case (kind)
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            9:       return a & b;
            10:      return a * b;
            default: return a + b;
        endcase
    endfunction

    task automatic report_error(input string name, input logic [31:0] expv,
                                input logic [31:0] gotv);
        errors = errors + 1;
        $display("** Error at %0t ns: %s expected %h got %h", $time, name, expv, gotv);
    endtask

    task automatic check_pending();
        checked = checked + 1;
        if (wb_valid !== p_valid) begin
            if (p_valid) begin
                errors = errors + 1;
                $display("no write-back seen for instruction %h at pc %h", p_ins, p_pc);
            end else begin
                report_error("wb_valid", 32'(p_valid), 32'(wb_valid));
            end
        end
        if (p_valid && wb_rd !== p_ins[11:7])
            report_error("wb_rd", 32'(p_ins[11:7]), 32'(wb_rd));
        if (p_valid && wb_data !== p_data)
            report_error("wb_data", p_data, wb_data);
        if (pc !== p_npc)
            report_error("pc", p_npc, pc);
        if (wb_pc !== p_pc)
            report_error("wb_pc", p_pc, wb_pc);
        if (branch_taken !== p_taken)
            report_error("branch_taken", 32'(p_taken), 32'(branch_taken));
        if (illegal !== p_ill)
            report_error("illegal", 32'(p_ill), 32'(illegal));
    endtask

    task automatic check_idle();
        if (wb_valid !== 1'b0)
            report_error("wb_valid", 32'd0, 32'(wb_valid));
        if (branch_taken !== 1'b0)
            report_error("branch_taken", 32'd0, 32'(branch_taken));
        if (illegal !== 1'b0)
            report_error("illegal", 32'd0, 32'(illegal));
        if (pc !== model_pc)
            report_error("pc", model_pc, pc);
    endtask

    // drive one instruction, check the one accepted on this edge, then advance the model
    task automatic issue(input logic [31:0] ins, input logic [31:0] e_data,
                         input logic [31:0] e_npc, input logic e_valid,
                         input logic e_taken, input logic e_ill);
        @(posedge clk);
        instr       <= ins;
        instr_valid <= 1'b1;
        @(negedge clk);
        if (pend)
            check_pending();
        pend    = 1'b1;
        p_ins   = ins;
        p_data  = e_data;
        p_npc   = e_npc;
        p_pc    = model_pc;
        p_valid = e_valid;
        p_taken = e_taken;
        p_ill   = e_ill;
        model_pc = e_npc;
        if (e_valid)
            model_regs[ins[11:7]] = e_data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            @(negedge clk);
            if (pend) begin
                check_pending();
                pend = 1'b0;
            end else begin
                check_idle();
            end
        end
    endtask

    // lui then addi, with the upper part rounded for the sign of the low twelve bits
    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        logic [31:0] rounded;
        logic [19:0] hi;
        rounded = v + 32'h800;
        hi = rounded[31:12];
        issue(upper_format(hi, r, op_lui), {hi, 12'b0}, model_pc + 32'd4, 1'b1, 1'b0, 1'b0);
        issue(imm_format(v[11:0], r, 3'd0, r, op_alui), v, model_pc + 32'd4, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic issue_rr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2);
        logic [31:0] expv;
        expv = rr_expect(kind, model_regs[rs1], model_regs[rs2]);
        issue(rr_instr(kind, rd, rs1, rs2), expv, model_pc + 32'd4, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic add_entry(input logic [31:0] ins, input logic [31:0] data,
                             input logic [31:0] npc, input logic valid,
                             input logic taken, input logic ill);
        table_q.push_back('{ins, data, npc, valid, taken, ill});
    endtask

    // expected values follow the pc from zero through the whole table
    task automatic build_table();
        add_entry(upper_format(20'h12345, 5'd1, op_lui), 32'h12345000, 32'd4, 1, 0, 0);
        add_entry(upper_format(20'h00001, 5'd2, op_auipc), 32'h00001004, 32'd8, 1, 0, 0);
        add_entry(imm_format(12'hffb, 5'd0, 3'd0, 5'd3, op_alui), 32'hfffffffb, 32'd12, 1, 0, 0);
        // srai against srli on a negative value
        add_entry(imm_format(12'h401, 5'd3, 3'd5, 5'd4, op_alui), 32'hfffffffd, 32'd16, 1, 0, 0);
        add_entry(imm_format(12'h001, 5'd3, 3'd5, 5'd5, op_alui), 32'h7ffffffd, 32'd20, 1, 0, 0);
        add_entry(imm_format(12'hfff, 5'd1, 3'd3, 5'd6, op_alui), 32'd1, 32'd24, 1, 0, 0);
        add_entry(imm_format(12'h000, 5'd3, 3'd2, 5'd7, op_alui), 32'd1, 32'd28, 1, 0, 0);
        add_entry(imm_format(12'h0ff, 5'd1, 3'd4, 5'd8, op_alui), 32'h123450ff, 32'd32, 1, 0, 0);
        add_entry(imm_format(12'h0f0, 5'd2, 3'd6, 5'd9, op_alui), 32'h000010f4, 32'd36, 1, 0, 0);
        add_entry(imm_format(12'h0f0, 5'd3, 3'd7, 5'd10, op_alui), 32'h000000f0, 32'd40, 1, 0, 0);
        add_entry(imm_format(12'h004, 5'd2, 3'd1, 5'd11, op_alui), 32'h00010040, 32'd44, 1, 0, 0);
        // x3 = -5, x6 = 1, x7 = 1, x1 positive
        add_entry(branch_format(13'd8, 5'd6, 5'd7, 3'd0), 32'd0, 32'd52, 0, 1, 0);
        add_entry(branch_format(13'd8, 5'd6, 5'd7, 3'd1), 32'd0, 32'd56, 0, 0, 0);
        add_entry(branch_format(13'd12, 5'd7, 5'd3, 3'd4), 32'd0, 32'd68, 0, 1, 0);
        add_entry(branch_format(13'd12, 5'd7, 5'd3, 3'd5), 32'd0, 32'd72, 0, 0, 0);
        add_entry(branch_format(13'd8, 5'd7, 5'd3, 3'd6), 32'd0, 32'd76, 0, 0, 0);
        add_entry(branch_format(-13'sd8, 5'd7, 5'd3, 3'd7), 32'd0, 32'd68, 0, 1, 0);
        add_entry(branch_format(13'd16, 5'd3, 5'd7, 3'd6), 32'd0, 32'd84, 0, 1, 0);
        add_entry(branch_format(13'd8, 5'd3, 5'd7, 3'd5), 32'd0, 32'd92, 0, 1, 0);
        add_entry(branch_format(13'd8, 5'd0, 5'd1, 3'd1), 32'd0, 32'd100, 0, 1, 0);
        add_entry(branch_format(13'd8, 5'd0, 5'd1, 3'd0), 32'd0, 32'd104, 0, 0, 0);
        add_entry(branch_format(13'd8, 5'd3, 5'd7, 3'd4), 32'd0, 32'd108, 0, 0, 0);
        add_entry(branch_format(13'd8, 5'd3, 5'd7, 3'd7), 32'd0, 32'd112, 0, 0, 0);
        // jal, then jalr to an odd sum, then jal to x0
        add_entry(jump_format(21'd16, 5'd12), 32'd116, 32'd128, 1, 1, 0);
        add_entry(imm_format(12'h011, 5'd2, 3'd0, 5'd13, op_jalr), 32'd132, 32'h1014, 1, 1, 0);
        add_entry(jump_format(-21'sd20, 5'd0), 32'd0, 32'h1000, 0, 1, 0);
        add_entry(imm_format(12'h007, 5'd0, 3'd0, 5'd14, op_alui), 32'd7, 32'h1004, 1, 0, 0);
        // load, store, fence and csrrw retire as no-ops
        add_entry(imm_format(12'h000, 5'd1, 3'd2, 5'd15, op_load), 32'd0, 32'h1008, 0, 0, 1);
        add_entry(reg_format(7'd0, 5'd1, 5'd0, 3'd2, 5'd4, op_store), 32'd0, 32'h100c, 0, 0, 1);
        add_entry(imm_format(12'h0ff, 5'd0, 3'd0, 5'd0, op_fence), 32'd0, 32'h1010, 0, 0, 1);
        add_entry(imm_format(12'h300, 5'd1, 3'd1, 5'd16, op_system), 32'd0, 32'h1014, 0, 0, 1);
        // x15 must still be zero after the load
        add_entry(imm_format(12'h003, 5'd15, 3'd0, 5'd17, op_alui), 32'd3, 32'h1018, 1, 0, 0);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic [4:0]  rd2;
        int          kind;

        // seed the generator once
        void'($urandom(8));
        errors      = 0;
        checked     = 0;
        cycles      = 0;
        pend        = 1'b0;
        model_pc    = '0;
        arst_n      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        cycle_limit = 2 * (table_q.size() + rand_count * rand_len + reset_cycles + 10) + 100;

        #1 arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle();
        if (wb_data !== '0)
            report_error("wb_data", 32'd0, wb_data);
        if (wb_rd !== '0)
            report_error("wb_rd", 32'd0, 32'(wb_rd));

        foreach (table_q[i]) begin
            issue(table_q[i].ins, table_q[i].data, table_q[i].npc, table_q[i].valid,
                  table_q[i].taken, table_q[i].ill);
        end
        // pc must hold while the source stalls
        idle(3);

        for (int n = 0; n < rand_count; n++) begin
            a = $urandom();
            b = $urandom();
            load_reg(5'd5, a);
            load_reg(5'd6, b);
            rd = 5'($urandom_range(31, 7));
            issue_rr(n % 11, rd, 5'd5, 5'd6);
            // reads the register written one cycle earlier
            kind = $urandom_range(10, 0);
            rd2 = 5'($urandom_range(31, 7));
            issue_rr(kind, rd2, rd, 5'd6);
        end
        idle(2);

        $display("instructions checked %0d, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rv_exec_props.sv */
// concurrent checks on the rv_exec retirement outputs; attached to rv_exec by bind
`timescale 1ns/1ns
`default_nettype none

module rv_exec_props (
    input logic                          clk,
    input logic                          arst_n,
    input logic [rv_pkg::xlen-1:0]       pc,
    input logic                          wb_valid,
    input logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input logic                          branch_taken,
    input logic                          illegal
);

    // a reported write never targets x0
    rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> wb_rd != '0)
        else $error("write-back reported with rd zero");

    valid_not_illegal: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_valid && illegal))
        else $error("wb_valid and illegal high together");

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[0] == 1'b0)
        else $error("pc bit 0 set");

    // outputs held clear during reset
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (pc == '0 && !wb_valid && !branch_taken && !illegal))
        else $error("outputs active while in reset");

endmodule

bind rv_exec rv_exec_props props0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .pc           (pc),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .branch_taken (branch_taken),
    .illegal      (illegal)
);

`default_nettype wire

/* design/rv_exec.sv */
// top of the rv32im execute subsystem; one instruction per valid strobe, registered write-back report
`timescale 1ns/1ns
`default_nettype none

module rv_exec (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          instr_valid,
    input  logic [rv_pkg::xlen-1:0]       instr,
    output logic [rv_pkg::xlen-1:0]       pc,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic [rv_pkg::xlen-1:0]       wb_pc,
    output logic                          branch_taken,
    output logic                          illegal
);
    import rv_pkg::*;

    // decoder outputs
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  branch_always;
    logic                  branch_instr;
    branch_op_t            branch_op;
    alu_a_sel_t            alu_a_sel;
    alu_b_sel_t            alu_b_sel;
    alu_op_t               alu_op;
    logic                  sub_arith;
    logic                  mul_en;
    wb_sel_t               wb_sel;
    logic                  wb_write_enable;
    logic                  dec_illegal;

    // data path
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] wb_value;
    logic            taken;
    logic            jalr;
    logic            rf_we;

    decoder u_decoder (
        .instr           (instr),
        .imm             (imm),
        .rs1             (rs1),
        .rs2             (rs2),
        .rd              (rd),
        .branch_always   (branch_always),
        .branch_instr    (branch_instr),
        .branch_op       (branch_op),
        .alu_a_sel       (alu_a_sel),
        .alu_b_sel       (alu_b_sel),
        .alu_op          (alu_op),
        .sub_arith       (sub_arith),
        .mul_en          (mul_en),
        .wb_sel          (wb_sel),
        .wb_write_enable (wb_write_enable),
        .illegal         (dec_illegal)
    );

    // write completes on the accepting edge, so no hazards
    assign rf_we = instr_valid & wb_write_enable;

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rd_addr  (rd),
        .rd_data  (wb_value),
        .we       (rf_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // operand muxes
    always_comb begin
        case (alu_a_sel)
            a_rs1:   alu_a = rs1_data;
            a_pc:    alu_a = pc;
            default: alu_a = '0;
        endcase
    end

    assign alu_b = (alu_b_sel == b_rs2) ? rs2_data : imm;

    alu u_alu (
        .a          (alu_a),
        .b          (alu_b),
        .alu_op     (alu_op),
        .sub_arith  (sub_arith),
        .mul_en     (mul_en),
        .result     (alu_result),
        .mul_result (mul_result)
    );

    // jal bases on pc, jalr on rs1
    assign jalr = branch_always & (alu_a_sel == a_rs1);

    branch_unit u_branch_unit (
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .branch_op     (branch_op),
        .branch_instr  (branch_instr),
        .branch_always (branch_always),
        .jalr          (jalr),
        .taken         (taken),
        .next_pc       (next_pc)
    );

    assign pc_plus4 = pc + pc_step;

    // write-back source
    always_comb begin
        case (wb_sel)
            wb_pc4:  wb_value = pc_plus4;
            wb_mul:  wb_value = mul_result;
            default: wb_value = alu_result;
        endcase
    end

    // pc and retirement report, one cycle after acceptance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= '0;
            wb_valid     <= 1'b0;
            wb_rd        <= '0;
            wb_data      <= '0;
            wb_pc        <= '0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            wb_valid     <= rf_we & (rd != '0);
            branch_taken <= instr_valid & taken;
            illegal      <= instr_valid & dec_illegal;
            if (instr_valid) begin
                pc      <= next_pc;
                wb_rd   <= rd;
                wb_data <= wb_value;
                wb_pc   <= pc;
            end
        end
    end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
// resolves branch conditions and jumps, and picks the next program counter
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  rv_pkg::branch_op_t      branch_op,
    input  logic                    branch_instr,
    input  logic                    branch_always,
    input  logic                    jalr,
    output logic                    taken,
    output logic [rv_pkg::xlen-1:0] next_pc
);
    import rv_pkg::*;

    logic            cond;
    logic [xlen-1:0] jalr_target;

    always_comb begin
        case (branch_op)
            br_beq:  cond = (rs1_data == rs2_data);
            br_bne:  cond = (rs1_data != rs2_data);
            br_blt:  cond = ($signed(rs1_data) < $signed(rs2_data));
            br_bge:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            br_bltu: cond = (rs1_data < rs2_data);
            br_bgeu: cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    // jumps always count as taken
    assign taken = branch_always | (branch_instr & cond);

    assign jalr_target = (rs1_data + imm) & ~{{(xlen-1){1'b0}}, 1'b1};

    assign next_pc = jalr  ? jalr_target :
                     taken ? (pc + imm)  :
                             (pc + pc_step);

endmodule

`default_nettype wire

/* design/alu.sv */
// integer alu of the execute stage; add/sub, shifts, compares, logic ops and the low-word multiply
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic                    sub_arith,
    input  logic                    mul_en,
    output logic [rv_pkg::xlen-1:0] result,
    output logic [rv_pkg::xlen-1:0] mul_result
);
    import rv_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] mul_a;
    logic [xlen-1:0] mul_b;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = sub_arith ? (a - b) : (a + b);
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, a < b};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sr: begin
                // arithmetic shift keeps the sign bit
                if (sub_arith) begin
                    result = $signed(a) >>> shamt;
                end else begin
                    result = a >> shamt;
                end
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // operands held at zero keep the multiplier quiet
    assign mul_a = mul_en ? a : '0;
    assign mul_b = mul_en ? b : '0;

    // low 32 bits only, same for signed and unsigned
    assign mul_result = mul_a * mul_b;

endmodule

`default_nettype wire

/* design/reg_file.sv */
// 32 x 32 integer register file with two combinational read ports and one write port, x0 reads zero
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [rv_pkg::xlen-1:0]       rd_data,
    input  logic                          we,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data
);
    import rv_pkg::*;

    // no storage behind x0
    logic [xlen-1:0] regs [1:reg_count-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // reads see the value before the edge, no bypass
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* design/decoder.sv */
// combinational rv32im decoder; turns one instruction into register indices, immediate and selects
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  logic [rv_pkg::xlen-1:0]       instr,
    // immediate
    output logic [rv_pkg::xlen-1:0]       imm,
    // register indices
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    // branch control
    output logic                          branch_always,
    output logic                          branch_instr,
    output rv_pkg::branch_op_t            branch_op,
    // alu control
    output rv_pkg::alu_a_sel_t            alu_a_sel,
    output rv_pkg::alu_b_sel_t            alu_b_sel,
    output rv_pkg::alu_op_t               alu_op,
    output logic                          sub_arith,
    output logic                          mul_en,
    // write-back control
    output rv_pkg::wb_sel_t               wb_sel,
    output logic                          wb_write_enable,
    output logic                          illegal
);
    import rv_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    opcode_t    opcode;

    // fixed field positions, shared by all formats
    assign funct7 = instr[31:25];
    assign rs2    = instr[24:20];
    assign rs1    = instr[19:15];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        // defaults describe a no-op
        imm             = '0;
        branch_always   = 1'b0;
        branch_instr    = 1'b0;
        branch_op       = br_beq;
        alu_a_sel       = a_rs1;
        alu_b_sel       = b_imm;
        alu_op          = alu_add;
        sub_arith       = 1'b0;
        mul_en          = 1'b0;
        wb_sel          = wb_alu;
        wb_write_enable = 1'b0;
        illegal         = 1'b0;

        case (opcode)
            op_lui: begin
                // u-type, 0 + imm
                imm             = {instr[31:12], 12'b0};
                alu_a_sel       = a_zero;
                wb_write_enable = 1'b1;
            end

            op_auipc: begin
                imm             = {instr[31:12], 12'b0};
                alu_a_sel       = a_pc;
                wb_write_enable = 1'b1;
            end

            op_jal: begin
                // j-type offset
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                alu_a_sel       = a_pc;
                branch_always   = 1'b1;
                wb_sel          = wb_pc4;
                wb_write_enable = 1'b1;
            end

            op_jalr: begin
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b000) begin
                    // rs1 as the alu a operand marks jalr for the top level
                    alu_a_sel       = a_rs1;
                    branch_always   = 1'b1;
                    wb_sel          = wb_pc4;
                    wb_write_enable = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end

            op_branch: begin
                // b-type offset
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                alu_a_sel = a_pc;
                case (funct3)
                    3'b010, 3'b011: begin
                        illegal = 1'b1;
                    end
                    default: begin
                        branch_instr = 1'b1;
                        branch_op    = branch_op_t'(funct3);
                    end
                endcase
            end

            op_alui: begin
                imm    = {{20{instr[31]}}, instr[31:20]};
                alu_op = alu_op_t'(funct3);
                if (funct3 == alu_sll && funct7 != funct7_base) begin
                    illegal = 1'b1;
                end else if (funct3 == alu_sr && funct7 != funct7_base
                             && funct7 != funct7_alt) begin
                    illegal = 1'b1;
                end else begin
                    // only srai takes bit 30, addi keeps adding
                    sub_arith       = (funct3 == alu_sr) ? instr[30] : 1'b0;
                    wb_write_enable = 1'b1;
                end
            end

            op_alu: begin
                alu_b_sel = b_rs2;
                alu_op    = alu_op_t'(funct3);
                if (funct7 == funct7_mul) begin
                    // low-word mul only, mulh* and div/rem rejected
                    if (funct3 == 3'b000) begin
                        mul_en          = 1'b1;
                        wb_sel          = wb_mul;
                        wb_write_enable = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 == funct7_base || (funct7 == funct7_alt
                             && (funct3 == alu_add || funct3 == alu_sr))) begin
                    sub_arith       = instr[30];
                    wb_write_enable = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end

            // memory, fence and csr are outside this core
            op_load, op_store, op_fence, op_system: begin
                illegal = 1'b1;
            end

            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
// shared widths, funct7 patterns and control encodings; imported by every module of the execute subsystem
`default_nettype none

package rv_pkg;

    // data path and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;

    // sequential pc increment
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // funct7 patterns of the register-register group
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;
    localparam logic [6:0] funct7_mul  = 7'b0000001;

    // base opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_alui   = 7'b0010011,
        op_alu    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_t;

    // alu operations, taken straight from funct3
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        // srl or sra, picked by sub_arith
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    // branch conditions, also funct3
    // 3'b010 and 3'b011 are not defined
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_op_t;

    // first alu operand
    typedef enum logic [1:0] {
        a_zero = 2'b00,
        a_rs1  = 2'b01,
        a_pc   = 2'b10
    } alu_a_sel_t;

    // second alu operand
    typedef enum logic [1:0] {
        b_rs2 = 2'b00,
        b_imm = 2'b01
    } alu_b_sel_t;

    // register write-back source
    typedef enum logic [1:0] {
        wb_alu = 2'b00,
        wb_pc4 = 2'b01,
        wb_mul = 2'b10
    } wb_sel_t;

endpackage

`default_nettype wire
